/* Makefile */
# Verilator build and run of the configuration slave testbench

VERILATOR ?= verilator
TOP       ?= cnfg_slave_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
HDRS := design/cnfg_defs.svh
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Simulation FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/cnfg_slave_tb.sv */
// Outputs sampled on the falling edge; one bus request at a time; responses may be held off
`timescale 1ns/1ps
`include "cnfg_defs.svh"

module cnfg_slave_tb;
  import cnfg_pkg::*;

  localparam int TIMEOUT_CYCLES = 200;

  localparam logic [3:0] OP_WR = 4'd0;
  localparam logic [3:0] OP_RD = 4'd1;
  localparam logic [3:0] OP_SNAP = 4'd2;
  localparam logic [3:0] OP_SAME = 4'd3;
  localparam logic [3:0] OP_IDLE = 4'd4;
  localparam logic [3:0] OP_READY = 4'd5;
  localparam logic [3:0] OP_DONE = 4'd6;
  localparam logic [3:0] OP_PF = 4'd7;
  localparam logic [3:0] OP_DRAIN = 4'd8;
  localparam logic [3:0] OP_IRQ = 4'd9;
  localparam logic [3:0] OP_DP = 4'd10;
  localparam logic [3:0] OP_RESTARTS = 4'd11;

  // One table row
  typedef struct packed {
    logic [3:0] op;
    reg_addr_t addr;
    word_t wdata;
    word_t exp;
  } step_t;

  logic aclk = 1'b0;
  logic aresetn;
  reg_req_t req;
  logic req_valid;
  logic req_ready;
  word_t rsp_data;
  logic rsp_valid;
  logic rsp_ready;
  dma_req_t rd_req;
  dma_req_t wr_req;
  logic rd_req_valid;
  logic wr_req_valid;
  logic rd_req_ready = 1'b0;
  logic wr_req_ready = 1'b0;
  done_t rd_done;
  done_t wr_done;
  pf_t rd_pf;
  pf_t wr_pf;
  logic pf_irq;
  logic pf_restart;
  logic decouple;

  step_t steps[$];
  dma_req_t exp_rd[$];
  dma_req_t exp_wr[$];
  vaddr_t st_vaddr_rd = '0;
  vaddr_t st_vaddr_wr = '0;
  len_t st_len_rd = '0;
  len_t st_len_wr = '0;
  word_t snap = '0;
  int errors = 0;
  int restarts = 0;
  bit aborted = 1'b0;
  logic [1:0] rdy_mode = 2'd0;
  integer seed = 53;

  cnfg_slave cnfg_slave_i (.*);

  initial
  begin
    forever #50 aclk = ~aclk;
  end

  // ----------------------------------------
  // DMA-side models
  // ----------------------------------------
  // Mode 0 holds ready low, 1 holds it high, 2 stalls at random
  always @(posedge aclk)
  begin
    case (rdy_mode)
      2'd0:
      begin
        rd_req_ready <= 1'b0;
        wr_req_ready <= 1'b0;
      end
      2'd1:
      begin
        rd_req_ready <= 1'b1;
        wr_req_ready <= 1'b1;
      end
      default:
      begin
        rd_req_ready <= ($random(seed) & 3) != 0;
        wr_req_ready <= ($random(seed) & 3) != 0;
      end
    endcase
  end

  // Handshake happens at the next rising edge
  always @(negedge aclk)
  begin
    if (rd_req_valid && rd_req_ready)
    begin
      if (exp_rd.size() == 0)
      begin
        errors++;
        $display("Read descriptor issued with none expected at %0t", $time);
      end
      else
      begin
        compare("rd_req", rd_req, exp_rd[0]);
        exp_rd.delete(0);
      end
    end
    if (wr_req_valid && wr_req_ready)
    begin
      if (exp_wr.size() == 0)
      begin
        errors++;
        $display("Write descriptor issued with none expected at %0t", $time);
      end
      else
      begin
        compare("wr_req", wr_req, exp_wr[0]);
        exp_wr.delete(0);
      end
    end
    if (pf_restart)
      restarts++;
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  task automatic compare(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp)
    begin
      errors++;
      $display("ERROR at %0t: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    aborted = 1'b1;
    $display("Gave up after %0d cycles waiting for %s at %0t", TIMEOUT_CYCLES, what, $time);
  endtask

  function automatic dma_req_t expected_desc(vaddr_t va, len_t ln, logic sy, logic st, dest_t ds);
    dma_req_t d;
    d.vaddr = va;
    d.len = ln;
    d.sync = sy;
    d.ctl = 1'b1;
    d.stream = st;
    d.dest = ds;
    return d;
  endfunction

  function automatic word_t rd_start(logic sync, logic stream, dest_t dest);
    word_t w;
    w = '0;
    w[`CTRL_START_RD] = 1'b1;
    w[`CTRL_SYNC_RD] = sync;
    w[`CTRL_STREAM_RD] = stream;
    w[`CTRL_DEST_RD +: 4] = dest;
    return w;
  endfunction

  function automatic word_t wr_start(logic sync, logic stream, dest_t dest);
    word_t w;
    w = '0;
    w[`CTRL_START_WR] = 1'b1;
    w[`CTRL_SYNC_WR] = sync;
    w[`CTRL_STREAM_WR] = stream;
    w[`CTRL_DEST_WR +: 4] = dest;
    return w;
  endfunction

  // Staged words and queue contents as the host sees them
  task automatic track_write(input reg_addr_t addr, input word_t wdata);
    case (addr)
      `REG_VADDR_RD: st_vaddr_rd = vaddr_t'(wdata);
      `REG_LEN_RD:   st_len_rd = len_t'(wdata);
      `REG_VADDR_WR: st_vaddr_wr = vaddr_t'(wdata);
      `REG_LEN_WR:   st_len_wr = len_t'(wdata);
      `REG_CTRL:
      begin
        if (wdata[`CTRL_START_RD] && exp_rd.size() < `CMD_QUEUE_DEPTH)
          exp_rd.push_back(expected_desc(st_vaddr_rd, st_len_rd, wdata[`CTRL_SYNC_RD],
                                         wdata[`CTRL_STREAM_RD], wdata[`CTRL_DEST_RD +: 4]));
        if (wdata[`CTRL_START_WR] && exp_wr.size() < `CMD_QUEUE_DEPTH)
          exp_wr.push_back(expected_desc(st_vaddr_wr, st_len_wr, wdata[`CTRL_SYNC_WR],
                                         wdata[`CTRL_STREAM_WR], wdata[`CTRL_DEST_WR +: 4]));
      end
      default: ;
    endcase
  endtask

  task automatic bus_access(input logic wr, input reg_addr_t addr, input word_t wdata,
                            output word_t rdata);
    int n;
    int stall;
    rdata = '0;
    @(posedge aclk);
    req.wr <= wr;
    req.addr <= addr;
    req.wdata <= wdata;
    req_valid <= 1'b1;
    n = 0;
    @(negedge aclk);
    while (!req_ready && n < TIMEOUT_CYCLES)
    begin
      @(negedge aclk);
      n++;
    end
    if (!req_ready)
      report_timeout("req_ready");
    else
    begin
      // Host takes the response up to three cycles late
      stall = $random(seed) & 3;
      @(posedge aclk);
      req_valid <= 1'b0;
      rsp_ready <= (stall == 0);
      n = 0;
      @(negedge aclk);
      while (!rsp_valid && n < TIMEOUT_CYCLES)
      begin
        @(negedge aclk);
        n++;
      end
      if (!rsp_valid)
        report_timeout("rsp_valid");
      else
      begin
        rdata = rsp_data;
        if (stall != 0)
        begin
          repeat (stall)
          begin
            @(negedge aclk);
            compare("rsp_valid while held", rsp_valid, 1'b1);
            compare("rsp_data while held", rsp_data, rdata);
          end
          @(posedge aclk);
          rsp_ready <= 1'b1;
        end
      end
    end
  endtask

  task automatic add_step(input logic [3:0] op, input reg_addr_t addr, input word_t wdata,
                          input word_t exp);
    step_t s;
    s.op = op;
    s.addr = addr;
    s.wdata = wdata;
    s.exp = exp;
    steps.push_back(s);
  endtask

  // ----------------------------------------
  // Stimulus table
  // ----------------------------------------
  task automatic build_steps();
    // Readback after reset
    add_step(OP_RD, `REG_TMR_STOP, 0, 64'd1);
    add_step(OP_WR, `REG_VADDR_RD, 64'hffff_1234_5678_9abc, 0);
    add_step(OP_RD, `REG_VADDR_RD, 0, 64'h0000_1234_5678_9abc);
    add_step(OP_WR, `REG_LEN_RD, 64'hffff_ffff_f123_4567, 0);
    add_step(OP_RD, `REG_LEN_RD, 0, 64'h0000_0000_0123_4567);
    add_step(OP_WR, `REG_VADDR_WR, 64'h0000_00ab_cdef_0040, 0);
    add_step(OP_RD, `REG_VADDR_WR, 0, 64'h0000_00ab_cdef_0040);
    add_step(OP_WR, `REG_LEN_WR, 64'h2000, 0);
    add_step(OP_RD, `REG_LEN_WR, 0, 64'h2000);
    add_step(OP_WR, `REG_TMR_STOP, 64'd7, 0);
    add_step(OP_RD, `REG_TMR_STOP, 0, 64'd7);
    add_step(OP_WR, `REG_TMR_STOP, 64'd1, 0);
    add_step(OP_RD, `REG_CTRL, 0, 0);
    // Descriptors under random stalls
    add_step(OP_READY, 0, 64'd2, 0);
    add_step(OP_WR, `REG_CTRL, rd_start(1'b1, 1'b0, 4'h3) | wr_start(1'b0, 1'b1, 4'hc), 0);
    add_step(OP_WR, `REG_VADDR_RD, 64'h1000, 0);
    add_step(OP_WR, `REG_CTRL, rd_start(1'b0, 1'b1, 4'h5), 0);
    add_step(OP_WR, `REG_VADDR_RD, 64'h2000, 0);
    add_step(OP_WR, `REG_LEN_RD, 64'h40, 0);
    add_step(OP_WR, `REG_CTRL, rd_start(1'b1, 1'b1, 4'h6) | wr_start(1'b1, 1'b0, 4'h7), 0);
    add_step(OP_WR, `REG_VADDR_WR, 64'h3000, 0);
    add_step(OP_WR, `REG_CTRL, wr_start(1'b0, 1'b0, 4'h8), 0);
    add_step(OP_DRAIN, 0, 0, 0);
    // Overflow with ready held low loses the ninth start
    add_step(OP_READY, 0, 64'd0, 0);
    for (int i = 0; i < 9; i++)
    begin
      add_step(OP_WR, `REG_VADDR_RD, 64'h5000 + 64'h100 * i, 0);
      add_step(OP_WR, `REG_CTRL, rd_start(i[0], i[1], dest_t'(i)), 0);
    end
    add_step(OP_IDLE, 0, 64'd2, 0);
    add_step(OP_RD, `REG_STAT_USED, 0, 64'd8);
    add_step(OP_READY, 0, 64'd1, 0);
    add_step(OP_DRAIN, 0, 0, 0);
    add_step(OP_RD, `REG_STAT_USED, 0, 0);
    // Completion and sent counters
    add_step(OP_WR, `REG_CTRL, (64'd1 << `CTRL_CLR_STAT_RD) | (64'd1 << `CTRL_CLR_STAT_WR), 0);
    add_step(OP_IDLE, 0, 64'd2, 0);
    add_step(OP_WR, `REG_CTRL, rd_start(1'b0, 1'b0, 4'h1) | wr_start(1'b0, 1'b0, 4'h2), 0);
    add_step(OP_WR, `REG_CTRL, rd_start(1'b1, 1'b0, 4'h1) | wr_start(1'b0, 1'b1, 4'h2), 0);
    add_step(OP_WR, `REG_CTRL, rd_start(1'b0, 1'b1, 4'h9), 0);
    add_step(OP_DRAIN, 0, 0, 0);
    add_step(OP_DONE, 0, {58'd0, 3'b111, 3'b110}, 0);
    add_step(OP_DONE, 0, {58'd0, 3'b000, 3'b001}, 0);
    add_step(OP_IDLE, 0, 64'd1, 0);
    add_step(OP_RD, `REG_STAT_DMA, 0, {32'd3, 32'd3});
    add_step(OP_RD, `REG_STAT_SENT, 0, {32'd2, 32'd3});
    add_step(OP_WR, `REG_CTRL, 64'd1 << `CTRL_CLR_STAT_RD, 0);
    add_step(OP_IDLE, 0, 64'd2, 0);
    add_step(OP_RD, `REG_STAT_DMA, 0, {32'd3, 32'd0});
    add_step(OP_RD, `REG_STAT_SENT, 0, {32'd2, 32'd0});
    // Page fault and interrupt
    add_step(OP_RD, `REG_STAT_PFAULTS, 0, 0);
    add_step(OP_IRQ, 0, 0, 0);
    add_step(OP_PF, 0, 64'h0000_7777_8888_9990, 64'h0abc_def);
    add_step(OP_IRQ, 0, 64'd1, 0);
    add_step(OP_RD, `REG_PF_VADDR, 0, 64'h0000_7777_8888_9990);
    add_step(OP_RD, `REG_PF_LEN, 0, 64'h0abc_def);
    add_step(OP_RD, `REG_STAT_PFAULTS, 0, 64'd1);
    add_step(OP_WR, `REG_CTRL, 64'd1 << `CTRL_CLR_IRQ, 0);
    add_step(OP_IDLE, 0, 64'd3, 0);
    add_step(OP_IRQ, 0, 0, 0);
    add_step(OP_RESTARTS, 0, 64'd1, 0);
    // Decouple word and timers
    add_step(OP_DP, 0, 0, 0);
    add_step(OP_WR, `REG_DP_SET, 64'd5, 0);
    add_step(OP_DP, 0, 64'd1, 0);
    add_step(OP_RD, `REG_DP_SET, 0, 64'd5);
    add_step(OP_RD, `REG_DP_CLR, 0, 64'd5);
    add_step(OP_WR, `REG_DP_CLR, 64'd1, 0);
    add_step(OP_DP, 0, 0, 0);
    add_step(OP_RD, `REG_DP_SET, 0, 64'd4);
    add_step(OP_WR, `REG_TMR_STOP, 0, 0);
    add_step(OP_IDLE, 0, 64'd2, 0);
    add_step(OP_SNAP, `REG_TMR_RD, 0, 0);
    add_step(OP_IDLE, 0, 64'd5, 0);
    add_step(OP_SAME, `REG_TMR_RD, 0, 0);
    add_step(OP_WR, `REG_CTRL, 64'd1 << `CTRL_CLR_STAT_RD, 0);
    add_step(OP_IDLE, 0, 64'd2, 0);
    add_step(OP_RD, `REG_TMR_RD, 0, 0);
  endtask

  task automatic run_step(input step_t s);
    word_t data;
    int n;
    case (s.op)
      OP_WR:
      begin
        // Expected descriptors are queued before the start write goes out
        track_write(s.addr, s.wdata);
        bus_access(1'b1, s.addr, s.wdata, data);
        if (!aborted)
          compare($sformatf("rsp_data of write to %0d", s.addr), data, 0);
      end
      OP_RD, OP_SNAP, OP_SAME:
      begin
        bus_access(1'b0, s.addr, 0, data);
        if (!aborted && s.op == OP_RD)
          compare($sformatf("rsp_data of read from %0d", s.addr), data, s.exp);
        if (!aborted && s.op == OP_SAME)
          compare($sformatf("rsp_data of repeated read from %0d", s.addr), data, snap);
        snap = data;
      end
      OP_IDLE: repeat (s.wdata) @(posedge aclk);
      OP_READY: rdy_mode = s.wdata[1:0];
      OP_DONE, OP_PF:
      begin
        @(posedge aclk);
        if (s.op == OP_DONE)
        begin
          rd_done <= s.wdata[2:0];
          wr_done <= s.wdata[5:3];
        end
        else
        begin
          rd_pf.miss <= 1'b1;
          rd_pf.vaddr <= vaddr_t'(s.wdata);
          rd_pf.len <= len_t'(s.exp);
          // A write-side miss in the same cycle loses to the read side
          wr_pf.miss <= 1'b1;
          wr_pf.vaddr <= ~vaddr_t'(s.wdata);
          wr_pf.len <= ~len_t'(s.exp);
        end
        @(posedge aclk);
        rd_done <= '0;
        wr_done <= '0;
        rd_pf <= '0;
        wr_pf <= '0;
      end
      OP_DRAIN:
      begin
        n = 0;
        while ((exp_rd.size() != 0 || exp_wr.size() != 0) && n < TIMEOUT_CYCLES)
        begin
          @(negedge aclk);
          n++;
        end
        if (exp_rd.size() != 0 || exp_wr.size() != 0)
          report_timeout("the expected descriptors to leave the queues");
      end
      OP_IRQ:
      begin
        @(negedge aclk);
        compare("pf_irq", pf_irq, s.wdata[0]);
      end
      OP_DP:
      begin
        @(negedge aclk);
        compare("decouple", decouple, s.wdata[0]);
      end
      OP_RESTARTS:
      begin
        @(negedge aclk);
        compare("pf_restart pulse count", restarts, s.wdata);
      end
      default: ;
    endcase
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial
  begin
    int i;
    aresetn = 1'b0;
    req = '0;
    req_valid = 1'b0;
    rsp_ready = 1'b1;
    rd_done = '0;
    wr_done = '0;
    rd_pf = '0;
    wr_pf = '0;
    build_steps();
    repeat (3) @(posedge aclk);
    aresetn <= 1'b1;
    for (i = 0; i < steps.size() && !aborted; i++)
      run_step(steps[i]);
    $display("Finished %0d of %0d steps with %0d error(s)", i, steps.size(), errors);
    if (errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

/* design/cmd_queue.sv */
// DEPTH must be a power of two; pushes into a full queue are silently dropped
`timescale 1ns/1ps
`include "cnfg_defs.svh"

module cmd_queue #(
  parameter int DEPTH = `CMD_QUEUE_DEPTH
) (
  input  logic               aclk,
  input  logic               aresetn,
  input  cnfg_pkg::dma_req_t in_data,
  input  logic               in_valid,
  output cnfg_pkg::dma_req_t out_data,
  output logic               out_valid,
  input  logic               out_ready,
  output cnfg_pkg::cnt_t     used
);
  import cnfg_pkg::*;

  localparam int PTR_BITS = $clog2(DEPTH);

  dma_req_t mem [DEPTH];
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [PTR_BITS:0] count;
  logic full;
  logic push;
  logic pop;

  assign full = (count == (PTR_BITS+1)'(DEPTH));
  assign push = in_valid && !full;
  assign pop = out_valid && out_ready;

  assign out_valid = (count != '0);
  assign out_data = mem[rd_ptr];
  assign used = cnt_t'(count);

  always_ff @(posedge aclk)
  begin
    if (push)
      mem[wr_ptr] <= in_data;
  end

  // Pointers wrap naturally at the power-of-two depth
  always_ff @(posedge aclk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  // Overflowing push is lost, occupancy stays pinned
  full_drop_a: assert property (@(posedge aclk) disable iff (!aresetn)
    in_valid && full && !pop |=> $stable(used));

endmodule

/* design/cnfg_defs.svh */
// Widths and word map are fixed; REG_* values must fit CNFG_ADDR_BITS, queue depth a power of two
`ifndef CNFG_DEFS_SVH
`define CNFG_DEFS_SVH

`define CNFG_DATA_BITS 64
`define CNFG_ADDR_BITS 4
`define CMD_QUEUE_DEPTH 8

// ----------------------------------------
// Register word addresses
// ----------------------------------------
`define REG_CTRL 4'd0
`define REG_VADDR_RD 4'd1
`define REG_LEN_RD 4'd2
`define REG_VADDR_WR 4'd3
`define REG_LEN_WR 4'd4
`define REG_PF_VADDR 4'd5
`define REG_PF_LEN 4'd6
`define REG_DP_SET 4'd7
`define REG_DP_CLR 4'd8
`define REG_TMR_STOP 4'd9
`define REG_TMR_RD 4'd10
`define REG_TMR_WR 4'd11
`define REG_STAT_USED 4'd12
`define REG_STAT_DMA 4'd13
`define REG_STAT_SENT 4'd14
`define REG_STAT_PFAULTS 4'd15

// ----------------------------------------
// Control word bit positions
// ----------------------------------------
`define CTRL_START_RD 0
`define CTRL_START_WR 1
`define CTRL_SYNC_RD 2
`define CTRL_SYNC_WR 3
`define CTRL_STREAM_RD 4
`define CTRL_STREAM_WR 5
`define CTRL_CLR_STAT_RD 6
`define CTRL_CLR_STAT_WR 7
`define CTRL_CLR_IRQ 8
`define CTRL_DEST_RD 9
`define CTRL_DEST_WR 13

`endif

/* design/cnfg_pkg.sv */
// Field widths are fixed here; stat_t layout is what the read multiplexer expects
`include "cnfg_defs.svh"

package cnfg_pkg;

  typedef logic [47:0] vaddr_t;
  typedef logic [27:0] len_t;
  typedef logic [3:0] dest_t;
  typedef logic [31:0] cnt_t;
  typedef logic [63:0] tmr_t;
  typedef logic [`CNFG_DATA_BITS-1:0] word_t;
  typedef logic [`CNFG_ADDR_BITS-1:0] reg_addr_t;

  // One DMA descriptor
  typedef struct packed {
    vaddr_t vaddr;
    len_t len;
    logic sync;
    logic ctl;
    logic stream;
    dest_t dest;
  } dma_req_t;

  // Single-beat register bus request
  typedef struct packed {
    logic wr;
    reg_addr_t addr;
    word_t wdata;
  } reg_req_t;

  typedef struct packed {
    logic miss;
    vaddr_t vaddr;
    len_t len;
  } pf_t;

  // Completion flags, any subset may be set
  typedef struct packed {
    logic host;
    logic card;
    logic sync;
  } done_t;

  typedef struct packed {
    cnt_t dma_rd;
    cnt_t dma_wr;
    cnt_t sent_rd;
    cnt_t sent_wr;
    cnt_t pfaults;
    tmr_t tmr_rd;
    tmr_t tmr_wr;
    word_t pf_vaddr;
    word_t pf_len;
  } stat_t;

endpackage

/* design/cnfg_reg_slave.sv */
// Single outstanding request only; whole-word writes, no strobes; REG_CTRL is write-only
`timescale 1ns/1ps
`include "cnfg_defs.svh"

module cnfg_reg_slave (
  input  logic              aclk,
  input  logic              aresetn,
  input  cnfg_pkg::reg_req_t req,
  input  logic              req_valid,
  output logic              req_ready,
  output cnfg_pkg::word_t   rsp_data,
  output logic              rsp_valid,
  input  logic              rsp_ready,
  output cnfg_pkg::dma_req_t rd_desc,
  output cnfg_pkg::dma_req_t wr_desc,
  output logic              rd_push,
  output logic              wr_push,
  input  cnfg_pkg::cnt_t    rd_used,
  input  cnfg_pkg::cnt_t    wr_used,
  input  cnfg_pkg::stat_t   stat,
  output cnfg_pkg::cnt_t    tmr_stop,
  output logic              clr_rd,
  output logic              clr_wr,
  output logic              clr_irq,
  output logic              decouple
);
  import cnfg_pkg::*;

  logic accept;
  logic wr_acc;
  logic ctrl_wr;
  logic rsp_pending;
  word_t rd_data;
  word_t dp_word;
  vaddr_t vaddr_rd;
  vaddr_t vaddr_wr;
  len_t len_rd;
  len_t len_wr;

  function automatic dma_req_t make_desc(vaddr_t va, len_t ln, logic sy, logic st, dest_t ds);
    dma_req_t d;
    d.vaddr = va;
    d.len = ln;
    d.sync = sy;
    d.ctl = 1'b1;
    d.stream = st;
    d.dest = ds;
    return d;
  endfunction

  // ----------------------------------------
  // Bus handshake
  // ----------------------------------------
  assign accept = req_valid && req_ready;
  assign wr_acc = accept && req.wr;
  assign ctrl_wr = wr_acc && (req.addr == `REG_CTRL);
  // Busy while a response is waiting or about to be issued
  assign rsp_pending = accept || (rsp_valid && !rsp_ready);

  always_ff @(posedge aclk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      rsp_valid <= 1'b0;
      req_ready <= 1'b0;
    end
    else
    begin
      rsp_valid <= rsp_pending;
      req_ready <= !rsp_pending;
    end
  end

  always_ff @(posedge aclk)
  begin
    if (accept)
      rsp_data <= req.wr ? '0 : rd_data;
  end

  // ----------------------------------------
  // Writable words
  // ----------------------------------------
  always_ff @(posedge aclk)
  begin
    if (wr_acc)
    begin
      case (req.addr)
        `REG_VADDR_RD: vaddr_rd <= vaddr_t'(req.wdata);
        `REG_LEN_RD:   len_rd <= len_t'(req.wdata);
        `REG_VADDR_WR: vaddr_wr <= vaddr_t'(req.wdata);
        `REG_LEN_WR:   len_wr <= len_t'(req.wdata);
        default: ;
      endcase
    end
  end

  always_ff @(posedge aclk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      dp_word <= '0;
      tmr_stop <= cnt_t'(1);
    end
    else if (wr_acc)
    begin
      case (req.addr)
        `REG_DP_SET:   dp_word <= dp_word | req.wdata;
        `REG_DP_CLR:   dp_word <= dp_word & ~req.wdata;
        `REG_TMR_STOP: tmr_stop <= cnt_t'(req.wdata);
        default: ;
      endcase
    end
  end

  assign decouple = dp_word[0];

  // ----------------------------------------
  // Control word into pulses
  // ----------------------------------------
  always_ff @(posedge aclk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      rd_push <= 1'b0;
      wr_push <= 1'b0;
      clr_rd <= 1'b0;
      clr_wr <= 1'b0;
      clr_irq <= 1'b0;
    end
    else
    begin
      rd_push <= ctrl_wr && req.wdata[`CTRL_START_RD];
      wr_push <= ctrl_wr && req.wdata[`CTRL_START_WR];
      clr_rd <= ctrl_wr && req.wdata[`CTRL_CLR_STAT_RD];
      clr_wr <= ctrl_wr && req.wdata[`CTRL_CLR_STAT_WR];
      clr_irq <= ctrl_wr && req.wdata[`CTRL_CLR_IRQ];
    end
  end

  // Descriptor takes staged address and length plus flags of the same control write
  always_ff @(posedge aclk)
  begin
    if (ctrl_wr)
    begin
      rd_desc <= make_desc(vaddr_rd, len_rd, req.wdata[`CTRL_SYNC_RD],
                           req.wdata[`CTRL_STREAM_RD], req.wdata[`CTRL_DEST_RD +: 4]);
      wr_desc <= make_desc(vaddr_wr, len_wr, req.wdata[`CTRL_SYNC_WR],
                           req.wdata[`CTRL_STREAM_WR], req.wdata[`CTRL_DEST_WR +: 4]);
    end
  end

  // ----------------------------------------
  // Read multiplexer
  // ----------------------------------------
  always_comb
  begin
    rd_data = '0;
    case (req.addr)
      `REG_VADDR_RD:     rd_data = word_t'(vaddr_rd);
      `REG_LEN_RD:       rd_data = word_t'(len_rd);
      `REG_VADDR_WR:     rd_data = word_t'(vaddr_wr);
      `REG_LEN_WR:       rd_data = word_t'(len_wr);
      `REG_PF_VADDR:     rd_data = stat.pf_vaddr;
      `REG_PF_LEN:       rd_data = stat.pf_len;
      `REG_DP_SET,
      `REG_DP_CLR:       rd_data = dp_word;
      `REG_TMR_STOP:     rd_data = word_t'(tmr_stop);
      `REG_TMR_RD:       rd_data = stat.tmr_rd;
      `REG_TMR_WR:       rd_data = stat.tmr_wr;
      `REG_STAT_USED:    rd_data = {wr_used, rd_used};
      `REG_STAT_DMA:     rd_data = {stat.dma_wr, stat.dma_rd};
      `REG_STAT_SENT:    rd_data = {stat.sent_wr, stat.sent_rd};
      `REG_STAT_PFAULTS: rd_data = word_t'(stat.pfaults);
      default: ;
    endcase
  end

  // Held response must not move until the host takes it
  rsp_hold_a: assert property (@(posedge aclk) disable iff (!aresetn)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data));

endmodule

/* design/cnfg_slave.sv */
// DMA engine must hold rd_pf/wr_pf miss for one cycle per fault; done inputs are single pulses
`timescale 1ns/1ps
`include "cnfg_defs.svh"

module cnfg_slave (
  input  logic               aclk,
  input  logic               aresetn,
  input  cnfg_pkg::reg_req_t req,
  input  logic               req_valid,
  output logic               req_ready,
  output cnfg_pkg::word_t    rsp_data,
  output logic               rsp_valid,
  input  logic               rsp_ready,
  output cnfg_pkg::dma_req_t rd_req,
  output cnfg_pkg::dma_req_t wr_req,
  output logic               rd_req_valid,
  output logic               wr_req_valid,
  input  logic               rd_req_ready,
  input  logic               wr_req_ready,
  input  cnfg_pkg::done_t    rd_done,
  input  cnfg_pkg::done_t    wr_done,
  input  cnfg_pkg::pf_t      rd_pf,
  input  cnfg_pkg::pf_t      wr_pf,
  output logic               pf_irq,
  output logic               pf_restart,
  output logic               decouple
);
  import cnfg_pkg::*;

  dma_req_t rd_desc;
  dma_req_t wr_desc;
  logic rd_push;
  logic wr_push;
  cnt_t rd_used;
  cnt_t wr_used;
  cnt_t tmr_stop;
  stat_t stat;
  logic clr_rd;
  logic clr_wr;
  logic clr_irq;
  logic rd_sent;
  logic wr_sent;

  // Descriptors handed to the DMA engine
  assign rd_sent = rd_req_valid && rd_req_ready;
  assign wr_sent = wr_req_valid && wr_req_ready;

  cnfg_reg_slave reg_slave_i (
    .aclk(aclk), .aresetn(aresetn),
    .req(req), .req_valid(req_valid), .req_ready(req_ready),
    .rsp_data(rsp_data), .rsp_valid(rsp_valid), .rsp_ready(rsp_ready),
    .rd_desc(rd_desc), .wr_desc(wr_desc), .rd_push(rd_push), .wr_push(wr_push),
    .rd_used(rd_used), .wr_used(wr_used), .stat(stat), .tmr_stop(tmr_stop),
    .clr_rd(clr_rd), .clr_wr(clr_wr), .clr_irq(clr_irq), .decouple(decouple)
  );

  cmd_queue #(.DEPTH(`CMD_QUEUE_DEPTH)) rd_queue_i (
    .aclk(aclk), .aresetn(aresetn),
    .in_data(rd_desc), .in_valid(rd_push),
    .out_data(rd_req), .out_valid(rd_req_valid), .out_ready(rd_req_ready),
    .used(rd_used)
  );

  cmd_queue #(.DEPTH(`CMD_QUEUE_DEPTH)) wr_queue_i (
    .aclk(aclk), .aresetn(aresetn),
    .in_data(wr_desc), .in_valid(wr_push),
    .out_data(wr_req), .out_valid(wr_req_valid), .out_ready(wr_req_ready),
    .used(wr_used)
  );

  cnfg_status status_i (
    .aclk(aclk), .aresetn(aresetn),
    .rd_done(rd_done), .wr_done(wr_done), .rd_pf(rd_pf), .wr_pf(wr_pf),
    .rd_sent(rd_sent), .wr_sent(wr_sent), .tmr_stop(tmr_stop),
    .clr_rd(clr_rd), .clr_wr(clr_wr), .clr_irq(clr_irq),
    .stat(stat), .pf_irq(pf_irq), .pf_restart(pf_restart)
  );

endmodule

/* design/cnfg_status.sv */
// Counters wrap at 32 bits; a read-side fault wins when both sides miss together
`timescale 1ns/1ps

module cnfg_status (
  input  logic            aclk,
  input  logic            aresetn,
  input  cnfg_pkg::done_t rd_done,
  input  cnfg_pkg::done_t wr_done,
  input  cnfg_pkg::pf_t   rd_pf,
  input  cnfg_pkg::pf_t   wr_pf,
  input  logic            rd_sent,
  input  logic            wr_sent,
  input  cnfg_pkg::cnt_t  tmr_stop,
  input  logic            clr_rd,
  input  logic            clr_wr,
  input  logic            clr_irq,
  output cnfg_pkg::stat_t stat,
  output logic            pf_irq,
  output logic            pf_restart
);
  import cnfg_pkg::*;

  cnt_t dma_rd;
  cnt_t dma_wr;
  cnt_t sent_rd;
  cnt_t sent_wr;
  cnt_t pfaults;
  tmr_t tmr_rd;
  tmr_t tmr_wr;
  vaddr_t pf_vaddr;
  len_t pf_len;
  logic miss;

  // One completion may report up to three done bits
  function automatic cnt_t done_bits(done_t d);
    return cnt_t'(d.host) + cnt_t'(d.card) + cnt_t'(d.sync);
  endfunction

  assign miss = rd_pf.miss || wr_pf.miss;

  // ----------------------------------------
  // Counters and timers
  // ----------------------------------------
  always_ff @(posedge aclk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      dma_rd <= '0;
      dma_wr <= '0;
      sent_rd <= '0;
      sent_wr <= '0;
      pfaults <= '0;
      tmr_rd <= '0;
      tmr_wr <= '0;
    end
    else
    begin
      dma_rd <= clr_rd ? '0 : dma_rd + done_bits(rd_done);
      dma_wr <= clr_wr ? '0 : dma_wr + done_bits(wr_done);
      sent_rd <= clr_rd ? '0 : sent_rd + cnt_t'(rd_sent);
      sent_wr <= clr_wr ? '0 : sent_wr + cnt_t'(wr_sent);
      pfaults <= (clr_rd || clr_wr) ? '0 : pfaults + cnt_t'(miss);
      // Timers freeze once enough completions are seen
      tmr_rd <= clr_rd ? '0 : (dma_rd < tmr_stop) ? tmr_rd + 1'b1 : tmr_rd;
      tmr_wr <= clr_wr ? '0 : (dma_wr < tmr_stop) ? tmr_wr + 1'b1 : tmr_wr;
    end
  end

  // ----------------------------------------
  // Page fault capture and interrupt
  // ----------------------------------------
  always_ff @(posedge aclk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      pf_vaddr <= '0;
      pf_len <= '0;
      pf_irq <= 1'b0;
      pf_restart <= 1'b0;
    end
    else
    begin
      pf_restart <= clr_irq;
      if (clr_irq)
        pf_irq <= 1'b0;
      // New miss beats a clear in the same cycle
      if (miss)
      begin
        pf_irq <= 1'b1;
        pf_vaddr <= rd_pf.miss ? rd_pf.vaddr : wr_pf.vaddr;
        pf_len <= rd_pf.miss ? rd_pf.len : wr_pf.len;
      end
    end
  end

  always_comb
  begin
    stat.dma_rd = dma_rd;
    stat.dma_wr = dma_wr;
    stat.sent_rd = sent_rd;
    stat.sent_wr = sent_wr;
    stat.pfaults = pfaults;
    stat.tmr_rd = tmr_rd;
    stat.tmr_wr = tmr_wr;
    stat.pf_vaddr = word_t'(pf_vaddr);
    stat.pf_len = word_t'(pf_len);
  end

endmodule

/* files.f */
+incdir+design
design/cnfg_pkg.sv
design/cmd_queue.sv
design/cnfg_reg_slave.sv
design/cnfg_status.sv
design/cnfg_slave.sv
bench/cnfg_slave_tb.sv
